// File: logic/tunnel_defs.svh
`ifndef TUNNEL_DEFS_SVH
`define TUNNEL_DEFS_SVH

// Number of independent channels sharing the link
`define TUNNEL_NUM_CH 2

// Payload bits carried per channel word
`define TUNNEL_WIDTH 16

// Receive buffer depth per channel, which is also the starting remote credit
`define TUNNEL_CREDITS 4

`endif

// File: logic/tunnel_pkg.sv
`default_nettype none

`include "tunnel_defs.svh"

package tunnel_pkg;

  // Channel number carried with every flit
  typedef logic [$clog2(`TUNNEL_NUM_CH)-1:0] chan_id_t;

  typedef logic [`TUNNEL_WIDTH-1:0] payload_t;

  // One link transfer, the channel tag sits above the payload
  typedef struct packed
  {
    chan_id_t id;
    payload_t data;
  } flit_t;

  // Holds 0 up to a full buffer of credits
  typedef logic [$clog2(`TUNNEL_CREDITS+1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: logic/tunnel_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tunnel_link_if;
  import tunnel_pkg::*;

  logic     flit_v;    // Flit is valid for this cycle only
  flit_t    flit;
  logic     credit_v;  // Returns one buffer slot
  chan_id_t credit_id;

  modport flit_src
  (output flit_v
  ,output flit
  );

  modport credit_src
  (output credit_v
  ,output credit_id
  );

  modport sink
  (input flit_v
  ,input flit
  );

  modport credit_sink
  (input credit_v
  ,input credit_id
  );

endinterface

`default_nettype wire

// File: logic/tunnel_tx_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_tx_mux
  (input  logic                                      clk_i
  ,input  logic                                      reset_i
  ,input  logic [`TUNNEL_NUM_CH-1:0]                 in_valid_i
  ,input  tunnel_pkg::payload_t [`TUNNEL_NUM_CH-1:0] in_data_i
  ,output logic [`TUNNEL_NUM_CH-1:0]                 in_ready_o
  ,tunnel_link_if.flit_src                           link_out
  ,tunnel_link_if.credit_sink                        link_in
  );

  import tunnel_pkg::*;

  credit_cnt_t [`TUNNEL_NUM_CH-1:0] credit_r;  // Free slots in the far end buffers
  chan_id_t                         rr_ptr_r;
  logic [`TUNNEL_NUM_CH-1:0]        eligible;
  logic                             grant_v;
  chan_id_t                         grant_id;
  logic                             flit_v_r;
  flit_t                            flit_r;

  always_comb
  begin
    for (int c = 0; c < `TUNNEL_NUM_CH; c++)
      eligible[c] = in_valid_i[c] && (credit_r[c] != '0);
  end

  // Search starts at the pointer and wraps around
  always_comb
  begin
    int idx;
    grant_v  = 1'b0;
    grant_id = '0;
    for (int k = 0; k < `TUNNEL_NUM_CH; k++)
    begin
      idx = (int'(rr_ptr_r) + k) % `TUNNEL_NUM_CH;
      if (!grant_v && eligible[idx])
      begin
        grant_v  = 1'b1;
        grant_id = chan_id_t'(idx);
      end
    end
  end

  always_comb
  begin
    in_ready_o = '0;
    if (grant_v)
      in_ready_o[grant_id] = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      flit_v_r <= 1'b0;
      rr_ptr_r <= '0;
      for (int c = 0; c < `TUNNEL_NUM_CH; c++)
        credit_r[c] <= credit_cnt_t'(`TUNNEL_CREDITS);
    end
    else
    begin
      flit_v_r <= grant_v;
      if (grant_v)
        rr_ptr_r <= (grant_id == chan_id_t'(`TUNNEL_NUM_CH-1)) ? '0 : grant_id + 1'b1;
      for (int c = 0; c < `TUNNEL_NUM_CH; c++)
        credit_r[c] <= credit_r[c]
                     + credit_cnt_t'(link_in.credit_v && (link_in.credit_id == chan_id_t'(c)))
                     - credit_cnt_t'(grant_v && (grant_id == chan_id_t'(c)));
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_v)
    begin
      flit_r.id   <= grant_id;
      flit_r.data <= in_data_i[grant_id];
    end
  end

  assign link_out.flit_v = flit_v_r;
  assign link_out.flit   = flit_r;

  for (genvar c = 0; c < `TUNNEL_NUM_CH; c++)
  begin : g_chk
    // Far end can never hand back more slots than it owns
    a_credit_max: assert property (@(posedge clk_i) disable iff (reset_i)
      credit_r[c] <= credit_cnt_t'(`TUNNEL_CREDITS));
  end

endmodule

`default_nettype wire

// File: logic/tunnel_rx_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_rx_demux
  (tunnel_link_if.sink                 link_in
  ,output logic [`TUNNEL_NUM_CH-1:0]   push_o
  ,output tunnel_pkg::payload_t        push_data_o
  );

  import tunnel_pkg::*;

  // One-hot write strobe from the flit tag
  always_comb
  begin
    push_o = '0;
    if (link_in.flit_v)
      push_o[link_in.flit.id] = 1'b1;
  end

  assign push_data_o = link_in.flit.data;  // Tag is dropped here

endmodule

`default_nettype wire

// File: logic/tunnel_chan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_chan_fifo
  (input  logic                 clk_i
  ,input  logic                 reset_i
  ,input  logic                 push_i
  ,input  tunnel_pkg::payload_t push_data_i
  ,input  logic                 pop_i
  ,output logic                 valid_o
  ,output tunnel_pkg::payload_t data_o
  );

  import tunnel_pkg::*;

  localparam int depth_lp = `TUNNEL_CREDITS;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;

  payload_t            mem_r [depth_lp];
  logic [ptr_w_lp-1:0] wptr_r;
  logic [ptr_w_lp-1:0] rptr_r;
  credit_cnt_t         count_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push_i)
        wptr_r <= (wptr_r == ptr_w_lp'(depth_lp-1)) ? '0 : wptr_r + 1'b1;
      if (pop_i)
        rptr_r <= (rptr_r == ptr_w_lp'(depth_lp-1)) ? '0 : rptr_r + 1'b1;
      count_r <= count_r + credit_cnt_t'(push_i) - credit_cnt_t'(pop_i);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wptr_r] <= push_data_i;
  end

  // Show-ahead read of the oldest word
  assign valid_o = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  // Sender only pushes against credits this buffer gave back
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    push_i |-> (count_r != credit_cnt_t'(depth_lp)));

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> (count_r != '0));

endmodule

`default_nettype wire

// File: logic/tunnel_credit_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_credit_return
  (input  logic                                      clk_i
  ,input  logic                                      reset_i
  ,input  logic [`TUNNEL_NUM_CH-1:0]                 buf_valid_i
  ,input  tunnel_pkg::payload_t [`TUNNEL_NUM_CH-1:0] buf_data_i
  ,input  logic [`TUNNEL_NUM_CH-1:0]                 out_ready_i
  ,output logic [`TUNNEL_NUM_CH-1:0]                 pop_o
  ,output logic [`TUNNEL_NUM_CH-1:0]                 out_valid_o
  ,output tunnel_pkg::payload_t [`TUNNEL_NUM_CH-1:0] out_data_o
  ,tunnel_link_if.credit_src                         link_out
  );

  import tunnel_pkg::*;

  credit_cnt_t [`TUNNEL_NUM_CH-1:0] pend_r;  // Delivered words not yet credited
  chan_id_t                         rr_ptr_r;
  logic                             pick_v;
  chan_id_t                         pick_id;

  // Buffer heads go straight out
  assign out_valid_o = buf_valid_i;
  assign out_data_o  = buf_data_i;
  assign pop_o       = buf_valid_i & out_ready_i;

  // Picks among channels that owe credits, starting at the pointer
  always_comb
  begin
    int idx;
    pick_v  = 1'b0;
    pick_id = '0;
    for (int k = 0; k < `TUNNEL_NUM_CH; k++)
    begin
      idx = (int'(rr_ptr_r) + k) % `TUNNEL_NUM_CH;
      if (!pick_v && (pend_r[idx] != '0))
      begin
        pick_v  = 1'b1;
        pick_id = chan_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rr_ptr_r <= '0;
      pend_r   <= '0;
    end
    else
    begin
      if (pick_v)
        rr_ptr_r <= (pick_id == chan_id_t'(`TUNNEL_NUM_CH-1)) ? '0 : pick_id + 1'b1;
      for (int c = 0; c < `TUNNEL_NUM_CH; c++)
        pend_r[c] <= pend_r[c]
                   + credit_cnt_t'(pop_o[c])
                   - credit_cnt_t'(pick_v && (pick_id == chan_id_t'(c)));
    end
  end

  // Pick depends only on registered state, so a credit trails its pop by a cycle
  assign link_out.credit_v  = pick_v;
  assign link_out.credit_id = pick_id;

  for (genvar c = 0; c < `TUNNEL_NUM_CH; c++)
  begin : g_chk
    a_pend_max: assert property (@(posedge clk_i) disable iff (reset_i)
      pend_r[c] <= credit_cnt_t'(`TUNNEL_CREDITS));
  end

endmodule

`default_nettype wire

// File: logic/tunnel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_top
  (input  logic                                      clk_i
  ,input  logic                                      reset_i

  ,input  logic [`TUNNEL_NUM_CH-1:0]                 in_valid_i
  ,input  tunnel_pkg::payload_t [`TUNNEL_NUM_CH-1:0] in_data_i
  ,output logic [`TUNNEL_NUM_CH-1:0]                 in_ready_o

  ,output logic [`TUNNEL_NUM_CH-1:0]                 out_valid_o
  ,output tunnel_pkg::payload_t [`TUNNEL_NUM_CH-1:0] out_data_o
  ,input  logic [`TUNNEL_NUM_CH-1:0]                 out_ready_i

  ,output logic                                      link_flit_v_o
  ,output tunnel_pkg::flit_t                         link_flit_o
  ,output logic                                      link_credit_v_o
  ,output tunnel_pkg::chan_id_t                      link_credit_id_o

  ,input  logic                                      link_flit_v_i
  ,input  tunnel_pkg::flit_t                         link_flit_i
  ,input  logic                                      link_credit_v_i
  ,input  tunnel_pkg::chan_id_t                      link_credit_id_i
  );

  import tunnel_pkg::*;

  tunnel_link_if link_out ();
  tunnel_link_if link_in ();

  logic [`TUNNEL_NUM_CH-1:0]     push_lo;
  payload_t                      push_data_lo;
  logic [`TUNNEL_NUM_CH-1:0]     pop_lo;
  logic [`TUNNEL_NUM_CH-1:0]     buf_valid_lo;
  payload_t [`TUNNEL_NUM_CH-1:0] buf_data_lo;

  assign link_flit_v_o    = link_out.flit_v;
  assign link_flit_o      = link_out.flit;
  assign link_credit_v_o  = link_out.credit_v;
  assign link_credit_id_o = link_out.credit_id;

  assign link_in.flit_v    = link_flit_v_i;
  assign link_in.flit      = link_flit_i;
  assign link_in.credit_v  = link_credit_v_i;
  assign link_in.credit_id = link_credit_id_i;

  tunnel_tx_mux u_tx_mux
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.in_valid_i (in_valid_i)
    ,.in_data_i  (in_data_i)
    ,.in_ready_o (in_ready_o)
    ,.link_out   (link_out.flit_src)
    ,.link_in    (link_in.credit_sink)
    );

  tunnel_rx_demux u_rx_demux
    (.link_in     (link_in.sink)
    ,.push_o      (push_lo)
    ,.push_data_o (push_data_lo)
    );

  for (genvar c = 0; c < `TUNNEL_NUM_CH; c++)
  begin : g_buf
    tunnel_chan_fifo u_fifo
      (.clk_i       (clk_i)
      ,.reset_i     (reset_i)
      ,.push_i      (push_lo[c])
      ,.push_data_i (push_data_lo)
      ,.pop_i       (pop_lo[c])
      ,.valid_o     (buf_valid_lo[c])
      ,.data_o      (buf_data_lo[c])
      );
  end

  tunnel_credit_return u_credit_return
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.buf_valid_i (buf_valid_lo)
    ,.buf_data_i  (buf_data_lo)
    ,.out_ready_i (out_ready_i)
    ,.pop_o       (pop_lo)
    ,.out_valid_o (out_valid_o)
    ,.out_data_o  (out_data_o)
    ,.link_out    (link_out.credit_src)
    );

endmodule

`default_nettype wire

// File: dv/tunnel_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tunnel_defs.svh"

module tunnel_tb;

  import tunnel_pkg::*;

  localparam int nch_lp       = `TUNNEL_NUM_CH;
  localparam int num_tests_lp = 5;
  localparam int stall_none   = 0;
  localparam int stall_hold   = 1;  // Channel 1 output held low until channel 0 is done
  localparam int stall_rand   = 2;

  // Stimulus table, one entry per test in every column
  string             test_name [num_tests_lp] = '{"single_ch0", "interleave", "credit_limit",
                                                  "credit_restore", "random_stall"};
  logic [nch_lp-1:0] test_mask [num_tests_lp] = '{2'b01, 2'b11, 2'b11, 2'b10, 2'b11};
  int                test_count [num_tests_lp][nch_lp] = '{'{20, 0}, '{16, 16},
                                                          '{12, `TUNNEL_CREDITS+2},
                                                          '{0, `TUNNEL_CREDITS}, '{24, 24}};
  int                test_stall [num_tests_lp] = '{stall_none, stall_none, stall_hold,
                                                   stall_none, stall_rand};
  bit                test_no_wait [num_tests_lp] = '{0, 0, 0, 1, 0};  // Credits must never run out

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic [nch_lp-1:0]     in_valid_i;
  payload_t [nch_lp-1:0] in_data_i;
  logic [nch_lp-1:0]     in_ready_o;
  logic [nch_lp-1:0]     out_valid_o;
  payload_t [nch_lp-1:0] out_data_o;
  logic [nch_lp-1:0]     out_ready_i;
  logic                  link_flit_v;
  flit_t                 link_flit;
  logic                  link_credit_v;
  chan_id_t              link_credit_id;

  payload_t exp_q [nch_lp][$];  // Words accepted and not yet delivered
  int       test_errors  = 0;
  int       tests_passed = 0;
  int       tests_failed = 0;
  int       cycles       = 0;
  int       cycle_limit  = 200;

  always #2 clk_i = ~clk_i;

  // The link outputs feed straight back into the link inputs
  tunnel_top u_dut
    (.clk_i            (clk_i)
    ,.reset_i          (reset_i)
    ,.in_valid_i       (in_valid_i)
    ,.in_data_i        (in_data_i)
    ,.in_ready_o       (in_ready_o)
    ,.out_valid_o      (out_valid_o)
    ,.out_data_o       (out_data_o)
    ,.out_ready_i      (out_ready_i)
    ,.link_flit_v_o    (link_flit_v)
    ,.link_flit_o      (link_flit)
    ,.link_credit_v_o  (link_credit_v)
    ,.link_credit_id_o (link_credit_id)
    ,.link_flit_v_i    (link_flit_v)
    ,.link_flit_i      (link_flit)
    ,.link_credit_v_i  (link_credit_v)
    ,.link_credit_id_i (link_credit_id)
    );

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input int c);
    payload_t exp_word;
    if (exp_q[c].size() == 0)
    begin
      $display("%s: channel %0d delivered %h with no word outstanding", name, c, out_data_o[c]);
      test_errors++;
    end
    else
    begin
      exp_word = exp_q[c].pop_front();
      if (out_data_o[c] !== exp_word)
      begin
        $display("ERR %s ch%0d expected %h actual %h", name, c, exp_word, out_data_o[c]);
        test_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("PASS %s", name);
    end
    else
    begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, test_errors);
    end
  endtask

  // Runs until no flit, credit or output word is left anywhere in the loop
  task automatic wait_idle(input string name);
    do
    begin
      @(posedge clk_i);
      in_valid_i  <= '0;
      out_ready_i <= '1;
      @(negedge clk_i);
      for (int c = 0; c < nch_lp; c++)
        if (out_valid_o[c] && out_ready_i[c])
          check_word(name, c);
    end while (link_flit_v || link_credit_v || (out_valid_o != '0));
  endtask

  task automatic run_test(input int t);
    int                sent [nch_lp];
    int                recv [nch_lp];
    int                waits [nch_lp];
    logic [nch_lp-1:0] took;
    bit                held;
    bit                done;
    bit                flit_due;
    flit_t             flit_exp;
    string             name;
    name        = test_name[t];
    test_errors = 0;
    held        = (test_stall[t] == stall_hold);
    took        = '0;
    done        = 1'b0;
    flit_due    = 1'b0;
    for (int c = 0; c < nch_lp; c++)
    begin
      sent[c]  = 0;
      recv[c]  = 0;
      waits[c] = 0;
    end
    while (!done)
    begin
      @(posedge clk_i);
      for (int c = 0; c < nch_lp; c++)
      begin
        in_valid_i[c] <= test_mask[t][c] && (sent[c] < test_count[t][c]);
        if (took[c] || !in_valid_i[c])
          in_data_i[c] <= payload_t'($urandom);  // Held steady while a word waits
        case (test_stall[t])
          stall_rand: out_ready_i[c] <= ($urandom % 2) == 0;
          stall_hold: out_ready_i[c] <= !(held && (c == 1));
          default:    out_ready_i[c] <= 1'b1;
        endcase
      end
      @(negedge clk_i);
      // A word accepted at the last edge is on the link now, tagged with its channel
      if (flit_due && !link_flit_v)
      begin
        $display("%s: no flit on the link one cycle after an accepted word", name);
        test_errors++;
      end
      else if (flit_due && (link_flit !== flit_exp))
      begin
        $display("ERR %s link flit expected %h actual %h", name, flit_exp, link_flit);
        test_errors++;
      end
      took     = in_valid_i & in_ready_o;
      flit_due = (took != '0);
      done     = 1'b1;
      for (int c = 0; c < nch_lp; c++)
      begin
        if (took[c])
        begin
          exp_q[c].push_back(in_data_i[c]);
          flit_exp.id   = chan_id_t'(c);
          flit_exp.data = in_data_i[c];
          sent[c]++;
        end
        else if (in_valid_i[c])
          waits[c]++;
        if (out_valid_o[c] && out_ready_i[c])
        begin
          check_word(name, c);
          recv[c]++;
        end
        if (recv[c] < test_count[t][c])
          done = 1'b0;
      end
      // Channel 0 is through, so channel 1 must be sitting at its credit limit
      if (held && (recv[0] == test_count[t][0]))
      begin
        if (sent[1] != `TUNNEL_CREDITS)
        begin
          $display("ERR %s ch1 accepted expected %0d actual %0d", name, `TUNNEL_CREDITS, sent[1]);
          test_errors++;
        end
        if (in_ready_o[1])
        begin
          $display("%s: channel 1 in_ready_o is high with no credit left", name);
          test_errors++;
        end
        held = 1'b0;
      end
    end
    wait_idle(name);
    for (int c = 0; c < nch_lp; c++)
    begin
      if (test_no_wait[t] && (waits[c] != 0))
      begin
        $display("%s: channel %0d waited %0d cycles for credit", name, c, waits[c]);
        test_errors++;
      end
      if (exp_q[c].size() != 0)
      begin
        $display("%s: channel %0d lost %0d words", name, c, exp_q[c].size());
        test_errors++;
        exp_q[c].delete();
      end
    end
    finish_test(name);
  endtask

  initial
  begin
    int total;
    void'($urandom(42539));
    total = 0;
    for (int t = 0; t < num_tests_lp; t++)
      for (int c = 0; c < nch_lp; c++)
        total += test_count[t][c];
    cycle_limit = 50 * total + 200;
    reset_i     = 1'b1;
    in_valid_i  = '0;
    in_data_i   = '0;
    out_ready_i = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    test_errors = 0;
    if ((out_valid_o != '0) || link_flit_v || link_credit_v)
    begin
      $display("reset_state: outputs not idle after reset, out_valid_o %b flit_v %b credit_v %b",
               out_valid_o, link_flit_v, link_credit_v);
      test_errors++;
    end
    finish_test("reset_state");
    for (int t = 0; t < num_tests_lp; t++)
      run_test(t);
    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/tunnel_pkg.sv
logic/tunnel_link_if.sv
logic/tunnel_tx_mux.sv
logic/tunnel_rx_demux.sv
logic/tunnel_chan_fifo.sv
logic/tunnel_credit_return.sv
logic/tunnel_top.sv
dv/tunnel_tb.sv

// File: Makefile
TOP := tunnel_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

# The run passes only when the pass message shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
